// ==== hdl/pipeline_macros.svh ====
`ifndef PIPELINE_MACROS_SVH
`define PIPELINE_MACROS_SVH

// Register and result width
`define DATA_W 32

// Architectural registers, r0 reads as zero
`define REG_COUNT 32

// Reorder buffer entries
// Must be a power of two so the tags wrap on their own
`define ROB_DEPTH 8

// Latency of the multiply path in cycles
`define MUL_STAGES 4

`endif

// ==== hdl/isa_pkg.sv ====
`include "pipeline_macros.svh"

package isa_pkg;

	typedef logic [`DATA_W-1:0] data_t;
	typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
	typedef logic [15:0] imm_t;

	typedef enum logic [5:0] {
		OP_ADD  = 6'h00,
		OP_SUB  = 6'h01,
		OP_AND  = 6'h02,
		OP_OR   = 6'h03,
		OP_XOR  = 6'h04,
		OP_ADDI = 6'h08,
		OP_MUL  = 6'h10
	} opcode_t;

	// Register form, rt in 15:11
	typedef struct packed {
		logic [5:0] opcode;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
		logic [10:0] spare;
	} r_fmt_t;

	// Immediate form, addi only
	typedef struct packed {
		logic [5:0] opcode;
		reg_idx_t rd;
		reg_idx_t rs;
		imm_t imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} inst_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_t;

	typedef struct packed {
		logic legal;
		logic slow; // Goes to the multiply path
		logic use_imm; // Second operand from imm
		logic use_rt;
		alu_op_t alu_op;
	} op_info_t;

endpackage

// ==== hdl/core_pkg.sv ====
`include "pipeline_macros.svh"

package core_pkg;

	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;
	typedef logic [$clog2(`ROB_DEPTH):0] rob_count_t; // One extra bit to tell full from empty

	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		isa_pkg::alu_op_t alu_op;
		logic slow;
		isa_pkg::data_t a;
		isa_pkg::data_t b;
	} issue_t;

	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		isa_pkg::data_t value;
	} completion_t;

	typedef struct packed {
		logic valid;
		isa_pkg::reg_idx_t rd;
		logic write;
		logic illegal;
	} alloc_t;

	typedef struct packed {
		logic valid;
		isa_pkg::reg_idx_t rd;
		logic write;
		logic illegal;
		isa_pkg::data_t value;
	} commit_t;

	// Four-phase receiver, ack is high outside IDLE
	typedef enum logic [1:0] {IDLE, ISSUE, WAIT_DROP} rx_state_t;

endpackage

// ==== hdl/register_bank.sv ====
`include "pipeline_macros.svh"

module register_bank (
	input logic clk,
	input logic reset,
	input isa_pkg::reg_idx_t rs_idx,
	input isa_pkg::reg_idx_t rt_idx,
	output isa_pkg::data_t rs_data,
	output isa_pkg::data_t rt_data,
	input core_pkg::commit_t commit
);
	import isa_pkg::*;

	data_t regs [`REG_COUNT];

	assign rs_data = regs[rs_idx]; // Plain array reads, no forwarding
	assign rt_data = regs[rt_idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (commit.valid && commit.write && commit.rd != '0) begin
			regs[commit.rd] <= commit.value; // r0 writes are dropped here
		end
	end

	// r0 keeps reading zero whatever the buffer retires
	a_zero_reg: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
		else $error("register zero was written");

endmodule

// ==== hdl/decode.sv ====
module decode (
	input logic clk,
	input logic reset,
	input logic inst_req,
	input isa_pkg::inst_t inst,
	output logic inst_ack,
	output isa_pkg::reg_idx_t rs_idx,
	output isa_pkg::reg_idx_t rt_idx,
	input isa_pkg::data_t rs_data,
	input isa_pkg::data_t rt_data,
	input logic dest_busy,
	input core_pkg::commit_t commit,
	input logic rob_full,
	input core_pkg::rob_tag_t rob_tail,
	output core_pkg::alloc_t alloc,
	output core_pkg::issue_t issue
);
	import isa_pkg::*;
	import core_pkg::*;

	rx_state_t state;
	op_info_t op;
	op_info_t op_q;
	reg_idx_t rd_q;
	data_t a_q;
	data_t b_q;
	data_t imm_ext;
	logic commit_hazard;
	logic accept;

	always_comb begin
		op = '{legal: 1'b1, slow: 1'b0, use_imm: 1'b0, use_rt: 1'b1, alu_op: ALU_ADD};
		case (inst.r.opcode)
			OP_ADD: op.alu_op = ALU_ADD;
			OP_SUB: op.alu_op = ALU_SUB;
			OP_AND: op.alu_op = ALU_AND;
			OP_OR: op.alu_op = ALU_OR;
			OP_XOR: op.alu_op = ALU_XOR;
			OP_ADDI: begin
				op.use_imm = 1'b1;
				op.use_rt = 1'b0;
			end
			OP_MUL: op.slow = 1'b1;
			default: begin
				op.legal = 1'b0; // Reads nothing, waits on nothing
				op.use_rt = 1'b0;
			end
		endcase
	end

	// Unused sources look up r0, which is never busy
	assign rs_idx = op.legal ? inst.r.rs : '0;
	assign rt_idx = op.use_rt ? inst.r.rt : '0;
	assign imm_ext = {{($bits(data_t) - $bits(imm_t)){inst.i.imm[15]}}, inst.i.imm};

	// Bank write lands on this edge, so the read below would be stale
	assign commit_hazard = commit.valid && commit.write && commit.rd != '0
		&& (commit.rd == rs_idx || commit.rd == rt_idx);
	assign accept = state == IDLE && inst_req && !rob_full && !dest_busy && !commit_hazard;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (accept) state <= ISSUE; // Ack rises with the issue
				ISSUE: state <= WAIT_DROP;
				WAIT_DROP: if (!inst_req) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op_q <= op;
			rd_q <= inst.r.rd;
			a_q <= rs_data;
			b_q <= op.use_imm ? imm_ext : rt_data;
		end
	end

	assign inst_ack = state != IDLE;

	always_comb begin
		alloc.valid = state == ISSUE;
		alloc.rd = rd_q;
		alloc.write = op_q.legal;
		alloc.illegal = !op_q.legal;
		issue.valid = state == ISSUE && op_q.legal;
		issue.tag = rob_tail; // Tail cannot move during ISSUE
		issue.alu_op = op_q.alu_op;
		issue.slow = op_q.slow;
		issue.a = a_q;
		issue.b = b_q;
	end

	// Requester keeps req up until it has seen ack
	a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(inst_ack) |-> inst_req)
		else $error("ack raised without a pending request");

endmodule

// ==== hdl/execute.sv ====
`include "pipeline_macros.svh"

module execute (
	input logic clk,
	input logic reset,
	input core_pkg::issue_t issue,
	output core_pkg::completion_t alu_done,
	output core_pkg::completion_t slow_done
);
	import isa_pkg::*;
	import core_pkg::*;

	data_t alu_result;
	data_t product;
	completion_t mul_pipe [`MUL_STAGES];

	always_comb begin
		case (issue.alu_op)
			ALU_ADD: alu_result = issue.a + issue.b; // Wraps
			ALU_SUB: alu_result = issue.a - issue.b;
			ALU_AND: alu_result = issue.a & issue.b;
			ALU_OR: alu_result = issue.a | issue.b;
			ALU_XOR: alu_result = issue.a ^ issue.b;
			default: alu_result = issue.a + issue.b;
		endcase
	end

	assign product = issue.a * issue.b; // Low DATA_W bits only

	// Fast path, one register
	always_ff @(posedge clk) begin
		alu_done.tag <= issue.tag;
		alu_done.value <= alu_result;
		if (reset) begin
			alu_done.valid <= 1'b0;
		end else begin
			alu_done.valid <= issue.valid && !issue.slow;
		end
	end

	// Slow path, product taken at issue and carried down the chain
	always_ff @(posedge clk) begin
		mul_pipe[0].tag <= issue.tag;
		mul_pipe[0].value <= product;
		for (int s = 1; s < `MUL_STAGES; s++) begin
			mul_pipe[s].tag <= mul_pipe[s-1].tag;
			mul_pipe[s].value <= mul_pipe[s-1].value;
		end
		if (reset) begin
			for (int s = 0; s < `MUL_STAGES; s++) begin
				mul_pipe[s].valid <= 1'b0;
			end
		end else begin
			mul_pipe[0].valid <= issue.valid && issue.slow;
			for (int s = 1; s < `MUL_STAGES; s++) begin
				mul_pipe[s].valid <= mul_pipe[s-1].valid;
			end
		end
	end

	assign slow_done = mul_pipe[`MUL_STAGES-1];

	// A tag is live in only one path at a time
	a_distinct_tags: assert property (@(posedge clk) disable iff (reset)
		alu_done.valid && slow_done.valid |-> alu_done.tag != slow_done.tag)
		else $error("both paths completed the same tag");

endmodule

// ==== hdl/reorder_buffer.sv ====
`include "pipeline_macros.svh"

module reorder_buffer (
	input logic clk,
	input logic reset,
	input core_pkg::alloc_t alloc,
	output core_pkg::rob_tag_t tail,
	output logic full,
	input isa_pkg::reg_idx_t rs_idx,
	input isa_pkg::reg_idx_t rt_idx,
	output logic dest_busy,
	input core_pkg::completion_t alu_done,
	input core_pkg::completion_t slow_done,
	output core_pkg::commit_t commit
);
	import isa_pkg::*;
	import core_pkg::*;

	typedef struct packed {
		reg_idx_t rd;
		logic write;
		logic illegal;
		data_t value;
	} entry_t;

	logic [`ROB_DEPTH-1:0] valid_q;
	logic [`ROB_DEPTH-1:0] done_q;
	entry_t entries [`ROB_DEPTH];
	rob_tag_t head;
	rob_count_t count;
	logic retire;

	assign full = count == rob_count_t'(`ROB_DEPTH);
	assign retire = valid_q[head] && done_q[head]; // In order, head only

	always_comb begin
		commit.valid = retire;
		commit.rd = entries[head].rd;
		commit.write = entries[head].write;
		commit.illegal = entries[head].illegal;
		commit.value = entries[head].value;
	end

	// Scoreboard over pending destinations, done or not
	always_comb begin
		dest_busy = 1'b0;
		for (int i = 0; i < `ROB_DEPTH; i++) begin
			if (valid_q[i] && entries[i].write && entries[i].rd != '0
				&& (entries[i].rd == rs_idx || entries[i].rd == rt_idx)) begin
				dest_busy = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			done_q <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (alloc.valid) begin
				valid_q[tail] <= 1'b1;
				done_q[tail] <= alloc.illegal; // Nothing to wait for
				tail <= tail + 1'b1;
			end
			if (alu_done.valid) done_q[alu_done.tag] <= 1'b1;
			if (slow_done.valid) done_q[slow_done.tag] <= 1'b1;
			if (retire) begin
				valid_q[head] <= 1'b0;
				head <= head + 1'b1;
			end
			count <= count + rob_count_t'(alloc.valid) - rob_count_t'(retire);
		end
	end

	always_ff @(posedge clk) begin
		if (alloc.valid) begin
			entries[tail].rd <= alloc.rd;
			entries[tail].write <= alloc.write;
			entries[tail].illegal <= alloc.illegal;
			entries[tail].value <= '0;
		end
		if (alu_done.valid) entries[alu_done.tag].value <= alu_done.value;
		if (slow_done.valid) entries[slow_done.tag].value <= slow_done.value;
	end

	a_alu_target: assert property (@(posedge clk) disable iff (reset)
		alu_done.valid |-> valid_q[alu_done.tag] && !done_q[alu_done.tag])
		else $error("ALU completion for a free or finished entry");
	a_slow_target: assert property (@(posedge clk) disable iff (reset)
		slow_done.valid |-> valid_q[slow_done.tag] && !done_q[slow_done.tag])
		else $error("multiply completion for a free or finished entry");
	a_no_overflow: assert property (@(posedge clk) disable iff (reset) alloc.valid |-> !full)
		else $error("allocation while the buffer is full");

endmodule

// ==== hdl/pipeline.sv ====
module pipeline (
	input logic clk,
	input logic reset,
	input logic inst_req,
	input isa_pkg::inst_t inst,
	output logic inst_ack,
	output core_pkg::commit_t commit
);
	import isa_pkg::*;
	import core_pkg::*;

	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	data_t rs_data;
	data_t rt_data;
	logic dest_busy;
	logic rob_full;
	rob_tag_t rob_tail;
	alloc_t alloc;
	issue_t issue;
	completion_t alu_done;
	completion_t slow_done;

	decode dec (
		.clk(clk),
		.reset(reset),
		.inst_req(inst_req),
		.inst(inst),
		.inst_ack(inst_ack),
		.rs_idx(rs_idx),
		.rt_idx(rt_idx),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.dest_busy(dest_busy),
		.commit(commit),
		.rob_full(rob_full),
		.rob_tail(rob_tail),
		.alloc(alloc),
		.issue(issue)
	);

	register_bank regs (
		.clk(clk),
		.reset(reset),
		.rs_idx(rs_idx),
		.rt_idx(rt_idx),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.commit(commit) // Retired results land here
	);

	execute exec (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.alu_done(alu_done),
		.slow_done(slow_done)
	);

	reorder_buffer rob (
		.clk(clk),
		.reset(reset),
		.alloc(alloc),
		.tail(rob_tail),
		.full(rob_full),
		.rs_idx(rs_idx), // Same indices as the bank read
		.rt_idx(rt_idx),
		.dest_busy(dest_busy),
		.alu_done(alu_done),
		.slow_done(slow_done),
		.commit(commit)
	);

endmodule

// ==== testbench/pipeline_tb.sv ====
`include "pipeline_macros.svh"

module pipeline_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import isa_pkg::*;
	import core_pkg::*;

	localparam int reset_cycles = 10;
	localparam int burst_len = `ROB_DEPTH + 4; // Longer than the buffer
	localparam int directed_insts = 35 + burst_len;
	localparam int random_insts = 200;
	localparam int cycles_per_inst = 30;
	localparam int watchdog_cycles = reset_cycles
		+ (directed_insts + random_insts) * cycles_per_inst;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic inst_req = 1'b0;
	inst_t inst = '0;
	logic inst_ack;
	commit_t commit;

	logic [31:0] lcg_state = 32'h08c1_b22b;
	data_t model_regs [`REG_COUNT] = '{default: '0};
	commit_t expected_q [$]; // Program order
	string name_q [$];

	pipeline u_dut (
		.clk(clk),
		.reset(reset),
		.inst_req(inst_req),
		.inst(inst),
		.inst_ack(inst_ack),
		.commit(commit)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic inst_t reg_inst(input logic [5:0] opcode, input reg_idx_t rd,
		input reg_idx_t rs, input reg_idx_t rt);
		inst_t word;
		word.r = '{opcode: opcode, rd: rd, rs: rs, rt: rt, spare: '0};
		return word;
	endfunction

	function automatic inst_t addi_inst(input reg_idx_t rd, input reg_idx_t rs,
		input imm_t imm);
		inst_t word;
		word.i = '{opcode: OP_ADDI, rd: rd, rs: rs, imm: imm};
		return word;
	endfunction

	// Sequential model of the ISA, one instruction at a time
	function automatic commit_t model_exec(input inst_t word);
		commit_t result;
		data_t a;
		data_t b;
		data_t imm_ext;
		a = model_regs[word.r.rs];
		b = model_regs[word.r.rt];
		imm_ext = {{(`DATA_W - 16){word.i.imm[15]}}, word.i.imm};
		result = '0;
		result.valid = 1'b1;
		result.rd = word.r.rd;
		result.write = 1'b1;
		case (word.r.opcode)
			OP_ADD: result.value = a + b;
			OP_SUB: result.value = a - b;
			OP_AND: result.value = a & b;
			OP_OR: result.value = a | b;
			OP_XOR: result.value = a ^ b;
			OP_ADDI: result.value = a + imm_ext;
			OP_MUL: result.value = a * b; // Low half only
			default: begin
				result.write = 1'b0;
				result.illegal = 1'b1;
			end
		endcase
		if (result.write && result.rd != '0) begin
			model_regs[result.rd] = result.value;
		end
		return result;
	endfunction

	task automatic check_value(input string name, input logic [$bits(commit_t)-1:0] expected,
		input logic [$bits(commit_t)-1:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "commit mismatch");
		end
	endtask

	// Four-phase transfer of one word
	task automatic send(input inst_t word, input string name);
		expected_q.push_back(model_exec(word));
		name_q.push_back(name);
		@(posedge clk);
		inst <= word;
		inst_req <= 1'b1;
		do @(posedge clk); while (!inst_ack);
		inst_req <= 1'b0;
		do @(posedge clk); while (inst_ack);
	endtask

	task automatic cover_alu_ops();
		send(addi_inst(5'd1, 5'd0, 16'd100), "alu_ops");
		send(addi_inst(5'd2, 5'd0, 16'hfff9), "alu_ops"); // -7
		send(addi_inst(5'd3, 5'd0, 16'h1234), "alu_ops");
		send(addi_inst(5'd10, 5'd2, 16'h8000), "alu_ops");
		send(reg_inst(OP_ADD, 5'd4, 5'd1, 5'd2), "alu_ops");
		send(reg_inst(OP_SUB, 5'd5, 5'd1, 5'd2), "alu_ops");
		send(reg_inst(OP_AND, 5'd6, 5'd1, 5'd3), "alu_ops");
		send(reg_inst(OP_OR, 5'd7, 5'd1, 5'd3), "alu_ops");
		send(reg_inst(OP_XOR, 5'd8, 5'd2, 5'd3), "alu_ops");
		send(reg_inst(OP_MUL, 5'd9, 5'd1, 5'd2), "alu_ops");
	endtask

	task automatic chain_dependencies();
		send(addi_inst(5'd11, 5'd0, 16'd1), "dependency_chain");
		repeat (8) send(reg_inst(OP_ADD, 5'd11, 5'd11, 5'd11), "dependency_chain");
		send(reg_inst(OP_MUL, 5'd12, 5'd11, 5'd11), "dependency_chain");
		send(reg_inst(OP_SUB, 5'd12, 5'd12, 5'd11), "dependency_chain");
	endtask

	// Fast ops queued right behind multiplies
	task automatic mix_multiplies();
		send(reg_inst(OP_MUL, 5'd13, 5'd1, 5'd3), "mul_mix");
		send(addi_inst(5'd14, 5'd0, 16'd5), "mul_mix");
		send(reg_inst(OP_XOR, 5'd15, 5'd3, 5'd1), "mul_mix");
		send(reg_inst(OP_MUL, 5'd16, 5'd2, 5'd3), "mul_mix");
		send(reg_inst(OP_ADD, 5'd17, 5'd1, 5'd3), "mul_mix");
		send(reg_inst(OP_OR, 5'd18, 5'd14, 5'd1), "mul_mix");
	endtask

	task automatic flood_multiplies();
		reg_idx_t rd;
		for (int i = 0; i < burst_len; i++) begin
			rd = reg_idx_t'(20 + i % 8); // Repeats destinations once the burst wraps
			send(reg_inst(OP_MUL, rd, reg_idx_t'(1 + i % 3), reg_idx_t'(2 + i % 2)),
				"back_pressure");
		end
	endtask

	task automatic probe_illegal_and_r0();
		send(reg_inst(6'h3f, 5'd5, 5'd1, 5'd2), "illegal_r0");
		send(reg_inst(6'h05, 5'd6, 5'd1, 5'd2), "illegal_r0");
		send(reg_inst(OP_ADD, 5'd28, 5'd5, 5'd0), "illegal_r0"); // r5 must be unchanged
		send(addi_inst(5'd0, 5'd0, 16'd77), "illegal_r0");
		send(reg_inst(OP_ADD, 5'd0, 5'd1, 5'd2), "illegal_r0");
		send(reg_inst(OP_ADD, 5'd29, 5'd0, 5'd1), "illegal_r0");
		send(reg_inst(OP_MUL, 5'd0, 5'd1, 5'd1), "illegal_r0");
		send(reg_inst(OP_OR, 5'd30, 5'd0, 5'd0), "illegal_r0");
	endtask

	task automatic play_random_program();
		logic [31:0] rnd;
		logic [31:0] imm_rnd;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
		for (int n = 0; n < random_insts; n++) begin
			rnd = lcg_next();
			imm_rnd = lcg_next();
			rd = reg_idx_t'(rnd[26:24]); // r0 to r7, lots of hazards
			rs = reg_idx_t'(rnd[22:20]);
			rt = reg_idx_t'(rnd[18:16]);
			case ((rnd >> 8) % 9)
				0: send(reg_inst(OP_ADD, rd, rs, rt), "random");
				1: send(reg_inst(OP_SUB, rd, rs, rt), "random");
				2: send(reg_inst(OP_AND, rd, rs, rt), "random");
				3: send(reg_inst(OP_OR, rd, rs, rt), "random");
				4: send(reg_inst(OP_XOR, rd, rs, rt), "random");
				5, 6: send(addi_inst(rd, rs, imm_t'(imm_rnd[31:16])), "random");
				7: send(reg_inst(OP_MUL, rd, rs, rt), "random");
				default: send(reg_inst(6'h2a, rd, rs, rt), "random");
			endcase
		end
	endtask

	always @(posedge clk) begin : compare
		commit_t exp_commit;
		string exp_name;
		if (!reset && commit.valid) begin
			if (expected_q.size() == 0) begin
				$display("Commit with nothing outstanding, rd %0d value %h",
					commit.rd, commit.value);
				$display("*** TEST FAILED ***");
				$fatal(1, "unexpected commit");
			end else begin
				exp_commit = expected_q.pop_front();
				exp_name = name_q.pop_front();
				check_value(exp_name, exp_commit, commit);
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles with %0d commits outstanding",
			watchdog_cycles, expected_q.size());
		$display("*** TEST FAILED ***");
		$fatal(1, "timeout");
	end

	initial begin
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		cover_alu_ops();
		chain_dependencies();
		mix_multiplies();
		flood_multiplies();
		probe_illegal_and_r0();
		play_random_program();
		while (expected_q.size() != 0) @(posedge clk);
		repeat (10) @(posedge clk); // Room for a stray commit to show up
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/register_bank.sv
hdl/decode.sv
hdl/execute.sv
hdl/reorder_buffer.sv
hdl/pipeline.sv
testbench/pipeline_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	-f vlog.f --top-module pipeline_tb -o pipeline_sim

./obj_dir/pipeline_sim
